// File: sources.f
+incdir+.
snn_spi_pkg.sv
spi_frame_rx.sv
cfg_reg_bank.sv
mem_access_port.sv
readback_tx.sv
snn_spi_top.sv
tb_spi_master.sv
tb_snn_spi.sv

// File: Makefile
SIM = obj_dir/sim

.PHONY: compile run clean

compile: $(SIM)

$(SIM): *.sv *.svh sources.f
	verilator --binary --assert --top-module tb_snn_spi -f sources.f -o sim

run: compile
	$(SIM) | tee sim.log
	grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: tb_snn_spi.sv
`default_nettype none

module tb_snn_spi;

    timeunit 1ns;
    timeprecision 100ps;

    // Frame words sent over all tests including idle words
    localparam int TOTAL_WORDS = 44;
    localparam int MAX_CYCLES  = TOTAL_WORDS * 32 + 256;

    logic                   SCK;
    logic                   RST_async;
    logic                   MOSI;
    logic                   MISO;
    snn_spi_pkg::cfg_top_t  cfg_top;
    snn_spi_pkg::cfg_ctrl_t cfg_ctrl;
    snn_spi_pkg::cfg_net_t  cfg_net;
    snn_spi_pkg::mem_req_t  mem_req;
    snn_spi_pkg::word_t     mem_rdata;

    snn_spi_pkg::cfg_top_t  exp_top;
    snn_spi_pkg::cfg_ctrl_t exp_ctrl;
    snn_spi_pkg::cfg_net_t  exp_net;

    integer seed = 32'hbd94;
    int     errors = 0;
    int     checks = 0;
    int     cycles = 0;

    // Strobes seen by the monitor
    logic [4:0]  prog_sel_q[$];
    logic [15:0] prog_addr_q[$];
    logic [31:0] prog_data_q[$];
    logic [4:0]  read_sel_q[$];
    logic [15:0] read_addr_q[$];

    // Readback collection
    int          rb_cnt = 0;
    logic [31:0] rb_word;
    logic [31:0] rb_q[$];

    snn_spi_top dut0 (
        .SCK       (SCK),
        .RST_async (RST_async),
        .MOSI      (MOSI),
        .MISO      (MISO),
        .cfg_top   (cfg_top),
        .cfg_ctrl  (cfg_ctrl),
        .cfg_net   (cfg_net),
        .mem_req   (mem_req),
        .mem_rdata (mem_rdata)
    );

    tb_spi_master master0 (
        .SCK  (SCK),
        .miso (MISO),
        .mosi (MOSI)
    );

    initial begin
        SCK = 1'b0;
        forever #2 SCK = ~SCK;
    end

    // --------------------
    // Memory model
    // --------------------

    // Model word for an address and a one-hot strobe
    // Strobe bit 0 is the neuron memory with target code 1
    function automatic logic [31:0] model_word(input logic [15:0] addr, input logic [4:0] sel);
        logic [31:0] code;
        code = 0;
        for (int i = 0; i < 5; i++) begin
            if (sel[i]) code = i + 1;
        end
        return ({16'h0, addr} ^ 32'hA5A5_0000) + code;
    endfunction

    assign mem_rdata = model_word(mem_req.addr, mem_req.read);

    task automatic expect_equal(input string name, input logic [191:0] exp,
                                input logic [191:0] act);
        checks++;
        assert (exp === act) else begin
            errors++;
            $display("Fail %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    // Strobes and MISO read in the middle of the cycle
    always @(negedge SCK) begin
        if (rb_cnt != 0) begin
            rb_word = {rb_word[30:0], MISO};
            rb_cnt--;
            if (rb_cnt == 0) begin
                rb_q.push_back(rb_word);
            end
        end
        if (|mem_req.prog) begin
            prog_sel_q.push_back(mem_req.prog);
            prog_addr_q.push_back(mem_req.addr);
            prog_data_q.push_back(mem_req.data);
        end
        if (|mem_req.read) begin
            read_sel_q.push_back(mem_req.read);
            read_addr_q.push_back(mem_req.addr);
            rb_cnt = 32;
        end
    end

    always @(posedge SCK) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Some tests failed");
            $finish;
        end
    end

    task automatic check_cfg(input string name);
        expect_equal({name, " cfg_top"}, 192'(exp_top), 192'(cfg_top));
        expect_equal({name, " cfg_ctrl"}, 192'(exp_ctrl), 192'(cfg_ctrl));
        expect_equal({name, " cfg_net"}, 192'(exp_net), 192'(cfg_net));
    endtask

    task automatic clear_queues();
        prog_sel_q.delete();
        prog_addr_q.delete();
        prog_data_q.delete();
        read_sel_q.delete();
        read_addr_q.delete();
        rb_q.delete();
    endtask

    // --------------------
    // Test sequence
    // --------------------
    initial begin
        logic [31:0] d;
        logic [31:0] words[$];
        logic [31:0] rx;

        RST_async = 1'b1;
        // Reset values from the register map
        exp_top = '0;
        exp_top.en_conf = 1'b1;
        exp_top.get_tar_req_out = 1'b1;
        exp_ctrl = '0;
        exp_ctrl.do_eprop = 3'd7;
        exp_ctrl.error_halt = 1'b1;
        exp_ctrl.single_label = 1'b1;
        exp_ctrl.send_label_only = 1'b1;
        exp_net = '0;
        exp_net.kappa = 8'h7A;
        exp_net.num_inp_neur = 8'hFF;
        exp_net.num_rec_neur = 8'hFF;
        exp_net.num_out_neur = 4'hF;

        repeat (3) @(posedge SCK);
        @(negedge SCK);
        RST_async = 1'b0;
        check_cfg("reset");
        expect_equal("reset prog", 192'(5'b0), 192'(mem_req.prog));
        expect_equal("reset read", 192'(5'b0), 192'(mem_req.read));

        // Single-word register writes
        d = $random(seed);
        // Data differs from the field so the write shows
        if (d[0] == exp_top.en_conf) begin
            d = ~d;
        end
        master0.write_one(3'd0, 16'd0, d);
        master0.send_idle();
        exp_top.en_conf = d[0];
        check_cfg("write en_conf");
        d = $random(seed);
        if (d[2:0] == exp_ctrl.do_eprop) begin
            d = ~d;
        end
        master0.write_one(3'd0, 16'd9, d);
        master0.send_idle();
        exp_ctrl.do_eprop = d[2:0];
        check_cfg("write do_eprop");
        d = $random(seed);
        master0.write_one(3'd0, 16'd22, d);
        master0.send_idle();
        exp_ctrl.sram_speedmode = d[7:0];
        check_cfg("write sram_speedmode");
        d = $random(seed);
        master0.write_one(3'd0, 16'd69, d);
        master0.send_idle();
        exp_net.kappa = d[7:0];
        check_cfg("write kappa");

        // Alpha burst and an unmapped address
        master0.send_word(master0.make_cmd(1'b0, 3'd0, 12'd4, 16'd65), rx);
        for (int i = 0; i < 4; i++) begin
            d = $random(seed);
            master0.send_word(d, rx);
            exp_net.alpha_conf[32*i +: 32] = d;
        end
        master0.send_idle();
        check_cfg("alpha burst");
        d = $random(seed);
        master0.write_one(3'd0, 16'd40, d);
        master0.send_idle();
        check_cfg("unmapped write");

        // Input weight memory burst
        clear_queues();
        master0.send_word(master0.make_cmd(1'b0, 3'd3, 12'd5, 16'h0100), rx);
        for (int i = 0; i < 5; i++) begin
            d = $random(seed);
            words.push_back(d);
            master0.send_word(d, rx);
        end
        master0.send_idle();
        expect_equal("winp prog count", 192'(5), 192'(prog_sel_q.size()));
        for (int i = 0; i < 5 && i < prog_sel_q.size(); i++) begin
            expect_equal("winp prog bit", 192'(5'b00100), 192'(prog_sel_q[i]));
            expect_equal("winp prog addr", 192'(16'h0100 + i), 192'(prog_addr_q[i]));
            expect_equal("winp prog data", 192'(words[i]), 192'(prog_data_q[i]));
        end
        expect_equal("winp read count", 192'(0), 192'(read_sel_q.size()));

        // Recurrent weight readback with one fetch per word
        clear_queues();
        master0.send_word(master0.make_cmd(1'b1, 3'd4, 12'd6, 16'h0200), rx);
        expect_equal("read cmd miso", 192'(32'h0), 192'(rx));
        for (int i = 0; i < 6; i++) begin
            master0.send_word('0, rx);
        end
        master0.send_idle();
        master0.send_idle();
        expect_equal("wrec read count", 192'(6), 192'(read_sel_q.size()));
        for (int i = 0; i < 6 && i < read_sel_q.size(); i++) begin
            expect_equal("wrec read bit", 192'(5'b01000), 192'(read_sel_q[i]));
            expect_equal("wrec read addr", 192'(16'h0200 + i), 192'(read_addr_q[i]));
        end
        expect_equal("wrec readback count", 192'(6), 192'(rb_q.size()));
        for (int i = 0; i < 6 && i < rb_q.size(); i++) begin
            expect_equal("wrec readback", 192'(model_word(16'h0200 + 16'(i), 5'b01000)),
                         192'(rb_q[i]));
        end
        expect_equal("wrec prog count", 192'(0), 192'(prog_sel_q.size()));

        // Command-only frames between two writes
        clear_queues();
        d = $random(seed);
        master0.write_one(3'd0, 16'd1, d);
        exp_top.ro_stage_sel = d[8:0];
        master0.send_word(master0.make_cmd(1'b0, 3'd5, 12'd0, 16'h0010), rx);
        master0.send_word(master0.make_cmd(1'b1, 3'd1, 12'd0, 16'h0020), rx);
        d = $random(seed);
        if (d[0] == exp_ctrl.force_traces) begin
            d = ~d;
        end
        master0.write_one(3'd0, 16'd33, d);
        master0.send_idle();
        exp_ctrl.force_traces = d[0];
        check_cfg("frame alignment");
        expect_equal("empty frame prog", 192'(0), 192'(prog_sel_q.size()));
        expect_equal("empty frame read", 192'(0), 192'(read_sel_q.size()));

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb_spi_master.sv
`default_nettype none

module tb_spi_master (
    input  wire logic SCK,
    input  wire logic miso,
    output logic      mosi
);

    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        mosi = 1'b0;
    end

    // --------------------
    // Command word layout
    // --------------------

    // Read flag, target, count and start address
    function automatic snn_spi_pkg::word_t make_cmd(
        input logic        rd,
        input logic [2:0]  tgt,
        input logic [11:0] n,
        input logic [15:0] addr
    );
        return {rd, tgt, n, addr};
    endfunction

    // --------------------
    // Word transfer
    // --------------------

    // Called on a falling edge, returns on the falling edge that starts the
    // next word, so back-to-back calls keep the stream gapless
    task automatic send_word(
        input  snn_spi_pkg::word_t w,
        output snn_spi_pkg::word_t rx
    );
        rx = '0;
        for (int i = 31; i >= 0; i--) begin
            mosi = w[i];
            @(negedge SCK);
            // MISO as it stands in the cycle after this bit was sampled
            rx[i] = miso;
        end
    endtask

    // A zero word is a write command to the registers with no data words
    task automatic send_idle();
        snn_spi_pkg::word_t rx;
        send_word('0, rx);
    endtask

    // Single data word write frame
    task automatic write_one(
        input logic [2:0]         tgt,
        input logic [15:0]        addr,
        input snn_spi_pkg::word_t data
    );
        snn_spi_pkg::word_t rx;
        send_word(make_cmd(1'b0, tgt, 12'd1, addr), rx);
        send_word(data, rx);
    endtask

endmodule

`default_nettype wire

// File: snn_spi_top.sv
`default_nettype none

module snn_spi_top (
    input  wire logic                SCK,
    input  wire logic                RST_async,
    input  wire logic                MOSI,
    output wire logic                MISO,
    output snn_spi_pkg::cfg_top_t    cfg_top,
    output snn_spi_pkg::cfg_ctrl_t   cfg_ctrl,
    output snn_spi_pkg::cfg_net_t    cfg_net,
    output snn_spi_pkg::mem_req_t    mem_req,
    input  wire snn_spi_pkg::word_t  mem_rdata
);

    snn_spi_pkg::spi_event_t evt;
    logic                    read_any;

    // --------------------
    // Frame decode
    // --------------------
    spi_frame_rx u_frame_rx (
        .SCK       (SCK),
        .RST_async (RST_async),
        .mosi      (MOSI),
        .evt       (evt)
    );

    // --------------------
    // Event consumers
    // --------------------
    cfg_reg_bank u_cfg_reg_bank (
        .SCK       (SCK),
        .RST_async (RST_async),
        .evt       (evt),
        .cfg_top   (cfg_top),
        .cfg_ctrl  (cfg_ctrl),
        .cfg_net   (cfg_net)
    );

    mem_access_port u_mem_access_port (
        .SCK       (SCK),
        .RST_async (RST_async),
        .evt       (evt),
        .mem_req   (mem_req)
    );

    // Any memory read loads the output shifter
    assign read_any = |mem_req.read;

    readback_tx u_readback_tx (
        .SCK       (SCK),
        .RST_async (RST_async),
        .read_any  (read_any),
        .mem_rdata (mem_rdata),
        .miso      (MISO)
    );

endmodule

`default_nettype wire

// File: readback_tx.sv
`default_nettype none
`include "snn_spi_consts.svh"

module readback_tx (
    input  wire logic                SCK,
    input  wire logic                RST_async,
    input  wire logic                read_any,
    input  wire snn_spi_pkg::word_t  mem_rdata,
    output wire logic                miso
);

    snn_spi_pkg::word_t shreg;

    // Memory answers during the strobe cycle, captured at its closing edge
    always_ff @(posedge SCK) begin
        if (RST_async) begin
            shreg <= '0;
        end else if (read_any) begin
            shreg <= mem_rdata;
        end else begin
            shreg <= {shreg[`SPI_WORD_BITS-2:0], 1'b0};
        end
    end

    // MSB first
    assign miso = shreg[`SPI_WORD_BITS-1];

endmodule

`default_nettype wire

// File: mem_access_port.sv
`default_nettype none
`include "snn_spi_consts.svh"

module mem_access_port (
    input  wire logic                     SCK,
    input  wire logic                     RST_async,
    input  wire snn_spi_pkg::spi_event_t  evt,
    output snn_spi_pkg::mem_req_t         mem_req
);

    logic [`NUM_MEMS-1:0] sel;
    logic                 mem_hit;

    // One-hot memory select, configuration target maps to nothing
    always_comb begin
        case (evt.target)
            snn_spi_pkg::NEUR:  sel = 5'b00001;
            snn_spi_pkg::ONEUR: sel = 5'b00010;
            snn_spi_pkg::WINP:  sel = 5'b00100;
            snn_spi_pkg::WREC:  sel = 5'b01000;
            snn_spi_pkg::WOUT:  sel = 5'b10000;
            default:            sel = '0;
        endcase
    end

    assign mem_hit = |sel;

    // --------------------
    // Strobes and payload
    // --------------------
    always_ff @(posedge SCK) begin
        if (RST_async) begin
            mem_req <= '0;
        end else begin
            // Strobes last a single cycle
            mem_req.prog <= '0;
            mem_req.read <= '0;
            if (evt.wr_valid && mem_hit) begin
                mem_req.prog <= sel;
                mem_req.addr <= evt.addr;
                mem_req.data <= evt.data;
            end
            // Reads keep the last written data on the bus
            if (evt.rd_valid && mem_hit) begin
                mem_req.read <= sel;
                mem_req.addr <= evt.addr;
            end
        end
    end

endmodule

`default_nettype wire

// File: cfg_reg_bank.sv
`default_nettype none
`include "snn_spi_consts.svh"

module cfg_reg_bank (
    input  wire logic                     SCK,
    input  wire logic                     RST_async,
    input  wire snn_spi_pkg::spi_event_t  evt,
    output snn_spi_pkg::cfg_top_t         cfg_top,
    output snn_spi_pkg::cfg_ctrl_t        cfg_ctrl,
    output snn_spi_pkg::cfg_net_t         cfg_net
);

    logic                   wr_cfg;
    snn_spi_pkg::cfg_addr_t alpha_off;
    logic                   alpha_hit;

    assign wr_cfg = evt.wr_valid && (evt.target == snn_spi_pkg::CFG);

    // Alpha spans four consecutive addresses, wraps below the base
    assign alpha_off = evt.addr - `ADDR_ALPHA_BASE;
    assign alpha_hit = (alpha_off < `ALPHA_WORDS);

    // --------------------
    // Toplevel group
    // --------------------
    always_ff @(posedge SCK) begin
        if (RST_async) begin
            cfg_top                 <= '0;
            cfg_top.en_conf         <= `RST_EN_CONF;
            cfg_top.get_tar_req_out <= `RST_GET_TAR_REQ_OUT;
        end else if (wr_cfg) begin
            case (evt.addr)
                `ADDR_EN_CONF:         cfg_top.en_conf         <= evt.data[0];
                `ADDR_RO_STAGE_SEL:    cfg_top.ro_stage_sel    <= evt.data[8:0];
                `ADDR_GET_CLKINT_OUT:  cfg_top.get_clkint_out  <= evt.data[0];
                `ADDR_GET_TAR_REQ_OUT: cfg_top.get_tar_req_out <= evt.data[0];
                default: ;
            endcase
        end
    end

    // --------------------
    // Control group
    // --------------------
    always_ff @(posedge SCK) begin
        if (RST_async) begin
            cfg_ctrl                 <= '0;
            cfg_ctrl.do_eprop        <= `RST_DO_EPROP;
            cfg_ctrl.error_halt      <= `RST_ERROR_HALT;
            cfg_ctrl.single_label    <= `RST_SINGLE_LABEL;
            cfg_ctrl.send_label_only <= `RST_SEND_LABEL_ONLY;
        end else if (wr_cfg) begin
            case (evt.addr)
                `ADDR_RST_MODE:          cfg_ctrl.rst_mode          <= evt.data[0];
                `ADDR_DO_EPROP:          cfg_ctrl.do_eprop          <= evt.data[2:0];
                `ADDR_LOCAL_TICK:        cfg_ctrl.local_tick        <= evt.data[0];
                `ADDR_ERROR_HALT:        cfg_ctrl.error_halt        <= evt.data[0];
                `ADDR_FP_LOC_WINP:       cfg_ctrl.fp_loc_winp       <= evt.data[2:0];
                `ADDR_FP_LOC_WREC:       cfg_ctrl.fp_loc_wrec       <= evt.data[2:0];
                `ADDR_FP_LOC_WOUT:       cfg_ctrl.fp_loc_wout       <= evt.data[2:0];
                `ADDR_FP_LOC_TINP:       cfg_ctrl.fp_loc_tinp       <= evt.data[2:0];
                `ADDR_FP_LOC_TREC:       cfg_ctrl.fp_loc_trec       <= evt.data[2:0];
                `ADDR_FP_LOC_TOUT:       cfg_ctrl.fp_loc_tout       <= evt.data[2:0];
                `ADDR_LEARN_SIG_SCALE:   cfg_ctrl.learn_sig_scale   <= evt.data[3:0];
                `ADDR_REGUL_MODE:        cfg_ctrl.regul_mode        <= evt.data[2:0];
                `ADDR_REGUL_W:           cfg_ctrl.regul_w           <= evt.data[1:0];
                `ADDR_EN_STOCH_ROUND:    cfg_ctrl.en_stoch_round    <= evt.data[0];
                `ADDR_SRAM_SPEEDMODE:    cfg_ctrl.sram_speedmode    <= evt.data[7:0];
                `ADDR_TIMING_MODE:       cfg_ctrl.timing_mode       <= evt.data[0];
                `ADDR_REGRESSION:        cfg_ctrl.regression        <= evt.data[0];
                `ADDR_SINGLE_LABEL:      cfg_ctrl.single_label      <= evt.data[0];
                `ADDR_NO_OUT_ACT:        cfg_ctrl.no_out_act        <= evt.data[0];
                `ADDR_SEND_PER_TIMESTEP: cfg_ctrl.send_per_timestep <= evt.data[0];
                `ADDR_SEND_LABEL_ONLY:   cfg_ctrl.send_label_only   <= evt.data[0];
                `ADDR_NOISE_EN:          cfg_ctrl.noise_en          <= evt.data[0];
                `ADDR_FORCE_TRACES:      cfg_ctrl.force_traces      <= evt.data[0];
                default: ;
            endcase
        end
    end

    // --------------------
    // Network group
    // --------------------
    always_ff @(posedge SCK) begin
        if (RST_async) begin
            cfg_net              <= '0;
            cfg_net.kappa        <= `RST_KAPPA;
            cfg_net.num_inp_neur <= `RST_NUM_INP;
            cfg_net.num_rec_neur <= `RST_NUM_REC;
            cfg_net.num_out_neur <= `RST_NUM_OUT;
        end else if (wr_cfg) begin
            case (evt.addr)
                `ADDR_CYCLES_PER_TICK: cfg_net.cycles_per_tick <= evt.data;
                `ADDR_KAPPA:           cfg_net.kappa           <= evt.data[7:0];
                `ADDR_NUM_INP:         cfg_net.num_inp_neur    <= evt.data[7:0];
                `ADDR_NUM_REC:         cfg_net.num_rec_neur    <= evt.data[7:0];
                `ADDR_NUM_OUT:         cfg_net.num_out_neur    <= evt.data[3:0];
                default: begin
                    // Word i of alpha sits at bits 32*i+31 down to 32*i
                    if (alpha_hit) begin
                        cfg_net.alpha_conf[{alpha_off[1:0], 5'b0} +: 32] <= evt.data;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: spi_frame_rx.sv
`default_nettype none
`include "snn_spi_consts.svh"

module spi_frame_rx (
    input  wire logic               SCK,
    input  wire logic               RST_async,
    input  wire logic               mosi,
    output snn_spi_pkg::spi_event_t evt
);

    snn_spi_pkg::word_t       shreg;
    snn_spi_pkg::word_t       word_in;
    snn_spi_pkg::word_t       cmd;
    logic [4:0]               bit_cnt;
    snn_spi_pkg::burst_len_t  word_cnt;
    logic                     last_bit;
    logic                     in_cmd;
    snn_spi_pkg::burst_len_t  new_len;
    snn_spi_pkg::burst_len_t  cmd_len;
    snn_spi_pkg::mem_target_e new_tgt;
    snn_spi_pkg::mem_target_e cmd_tgt;
    snn_spi_pkg::cfg_addr_t   cmd_addr;
    snn_spi_pkg::cfg_addr_t   data_addr;

    // --------------------
    // Input shifter
    // --------------------

    // Full word as seen at the edge that samples its last bit
    assign word_in  = {shreg[`SPI_WORD_BITS-2:0], mosi};
    assign last_bit = (bit_cnt == 5'd31);

    always_ff @(posedge SCK) begin
        if (RST_async) begin
            shreg   <= '0;
            bit_cnt <= '0;
        end else begin
            shreg   <= word_in;
            bit_cnt <= bit_cnt + 5'd1;
        end
    end

    // --------------------
    // Frame tracking
    // --------------------

    // Word 0 of a frame is the command
    assign in_cmd  = (word_cnt == '0);
    assign new_len = word_in[`CMD_CNT_MSB:`CMD_CNT_LSB];
    assign new_tgt = snn_spi_pkg::mem_target_e'(word_in[`CMD_TGT_MSB:`CMD_TGT_LSB]);

    assign cmd_len  = cmd[`CMD_CNT_MSB:`CMD_CNT_LSB];
    assign cmd_tgt  = snn_spi_pkg::mem_target_e'(cmd[`CMD_TGT_MSB:`CMD_TGT_LSB]);
    assign cmd_addr = cmd[`CMD_ADDR_MSB:0];

    // Address of data word k is start + k - 1
    assign data_addr = cmd_addr + snn_spi_pkg::cfg_addr_t'(word_cnt) - 16'd1;

    always_ff @(posedge SCK) begin
        if (RST_async) begin
            cmd      <= '0;
            word_cnt <= '0;
        end else if (last_bit) begin
            if (in_cmd) begin
                cmd <= word_in;
                // Command-only frame leaves the counter on word 0
                if (new_len != '0) begin
                    word_cnt <= 12'd1;
                end
            end else if (word_cnt == cmd_len) begin
                word_cnt <= '0;
            end else begin
                word_cnt <= word_cnt + 12'd1;
            end
        end
    end

    // --------------------
    // Event generation
    // --------------------
    always_ff @(posedge SCK) begin
        if (RST_async) begin
            evt <= '0;
        end else begin
            evt.wr_valid <= 1'b0;
            evt.rd_valid <= 1'b0;
            if (last_bit && in_cmd) begin
                // Read bursts fetch the first word right after the command
                if (word_in[`CMD_RW_BIT] && (new_len != '0)) begin
                    evt.rd_valid <= 1'b1;
                    evt.target   <= new_tgt;
                    evt.addr     <= word_in[`CMD_ADDR_MSB:0];
                end
            end else if (last_bit) begin
                evt.target <= cmd_tgt;
                if (!cmd[`CMD_RW_BIT]) begin
                    evt.wr_valid <= 1'b1;
                    evt.addr     <= data_addr;
                    evt.data     <= word_in;
                end else if (word_cnt < cmd_len) begin
                    // Prefetch the word shifted out during the next data word
                    evt.rd_valid <= 1'b1;
                    evt.addr     <= data_addr + 16'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: snn_spi_pkg.sv
`default_nettype none
`include "snn_spi_consts.svh"

package snn_spi_pkg;

    typedef logic [`SPI_WORD_BITS-1:0] word_t;
    typedef logic [`CMD_ADDR_MSB:0] cfg_addr_t;
    typedef logic [`CMD_CNT_MSB-`CMD_CNT_LSB:0] burst_len_t;

    // Target field of the command word
    typedef enum logic [2:0] {
        CFG   = 3'd0,
        NEUR  = 3'd1,
        ONEUR = 3'd2,
        WINP  = 3'd3,
        WREC  = 3'd4,
        WOUT  = 3'd5
    } mem_target_e;

    // One decoded word of a frame, valid for a single cycle
    typedef struct packed {
        logic        wr_valid;
        logic        rd_valid;
        mem_target_e target;
        cfg_addr_t   addr;
        word_t       data;
    } spi_event_t;

    // --------------------
    // Configuration groups
    // --------------------
    typedef struct packed {
        logic       en_conf;
        logic [8:0] ro_stage_sel;
        logic       get_clkint_out;
        logic       get_tar_req_out;
    } cfg_top_t;

    typedef struct packed {
        logic       rst_mode;
        logic [2:0] do_eprop;
        logic       local_tick;
        logic       error_halt;
        logic [2:0] fp_loc_winp;
        logic [2:0] fp_loc_wrec;
        logic [2:0] fp_loc_wout;
        logic [2:0] fp_loc_tinp;
        logic [2:0] fp_loc_trec;
        logic [2:0] fp_loc_tout;
        logic [3:0] learn_sig_scale;
        logic [2:0] regul_mode;
        logic [1:0] regul_w;
        logic       en_stoch_round;
        logic [7:0] sram_speedmode;
        logic       timing_mode;
        logic       regression;
        logic       single_label;
        logic       no_out_act;
        logic       send_per_timestep;
        logic       send_label_only;
        logic       noise_en;
        logic       force_traces;
    } cfg_ctrl_t;

    typedef struct packed {
        logic [31:0]  cycles_per_tick;
        logic [127:0] alpha_conf;
        logic [7:0]   kappa;
        logic [7:0]   num_inp_neur;
        logic [7:0]   num_rec_neur;
        logic [3:0]   num_out_neur;
    } cfg_net_t;

    // Strobes toward the network memories, bit 0 is the neuron memory
    typedef struct packed {
        logic [`NUM_MEMS-1:0] prog;
        logic [`NUM_MEMS-1:0] read;
        cfg_addr_t            addr;
        word_t                data;
    } mem_req_t;

endpackage

`default_nettype wire

// File: snn_spi_consts.svh
`ifndef SNN_SPI_CONSTS_SVH
`define SNN_SPI_CONSTS_SVH

// --------------------
// Serial word layout
// --------------------
`define SPI_WORD_BITS          32
`define CMD_RW_BIT             31
`define CMD_TGT_MSB            30
`define CMD_TGT_LSB            28
`define CMD_CNT_MSB            27
`define CMD_CNT_LSB            16
`define CMD_ADDR_MSB           15

// One prog strobe and one read strobe per network memory
`define NUM_MEMS               5

// --------------------
// Register map
// --------------------
// Toplevel group
`define ADDR_EN_CONF           16'd0
`define ADDR_RO_STAGE_SEL      16'd1
`define ADDR_GET_CLKINT_OUT    16'd2
`define ADDR_GET_TAR_REQ_OUT   16'd3

// Control group
`define ADDR_RST_MODE          16'd8
`define ADDR_DO_EPROP          16'd9
`define ADDR_LOCAL_TICK        16'd10
`define ADDR_ERROR_HALT        16'd11
`define ADDR_FP_LOC_WINP       16'd12
`define ADDR_FP_LOC_WREC       16'd13
`define ADDR_FP_LOC_WOUT       16'd14
`define ADDR_FP_LOC_TINP       16'd15
`define ADDR_FP_LOC_TREC       16'd16
`define ADDR_FP_LOC_TOUT       16'd17
`define ADDR_LEARN_SIG_SCALE   16'd18
`define ADDR_REGUL_MODE        16'd19
`define ADDR_REGUL_W           16'd20
`define ADDR_EN_STOCH_ROUND    16'd21
`define ADDR_SRAM_SPEEDMODE    16'd22
`define ADDR_TIMING_MODE       16'd23
`define ADDR_REGRESSION        16'd25
`define ADDR_SINGLE_LABEL      16'd26
`define ADDR_NO_OUT_ACT        16'd27
`define ADDR_SEND_PER_TIMESTEP 16'd30
`define ADDR_SEND_LABEL_ONLY   16'd31
`define ADDR_NOISE_EN          16'd32
`define ADDR_FORCE_TRACES      16'd33

// Network group
`define ADDR_CYCLES_PER_TICK   16'd64
`define ADDR_ALPHA_BASE        16'd65
`define ALPHA_WORDS            16'd4
`define ADDR_KAPPA             16'd69
`define ADDR_NUM_INP           16'd94
`define ADDR_NUM_REC           16'd95
`define ADDR_NUM_OUT           16'd96

// --------------------
// Non-zero reset values
// --------------------
`define RST_EN_CONF            1'b1
`define RST_GET_TAR_REQ_OUT    1'b1
`define RST_ERROR_HALT         1'b1
`define RST_SINGLE_LABEL       1'b1
`define RST_SEND_LABEL_ONLY    1'b1
`define RST_DO_EPROP           3'd7
`define RST_KAPPA              8'h7A
`define RST_NUM_INP            8'hFF
`define RST_NUM_REC            8'hFF
`define RST_NUM_OUT            4'hF

`endif
